// ==== design/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// first fetch address after reset
`define FETCH_RESET_PC 64'h0000_0000_8000_0000

// instruction queue entries, power of two
`define FETCH_QUEUE_DEPTH 4

// major opcode of jal
`define OPC_JAL 7'b110_1111

`endif

// ==== design/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // byte address, pc and bus address alike
    typedef logic [63:0] addr_t;

    // one uncompressed instruction word
    typedef logic [31:0] inst_t;

    // item passed from fetch through the queue to predecode
    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } fetch_item_t;

    // pc redirect from predecode back to fetch
    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    // read bus master states
    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   trap_i,
    input  fetch_pkg::addr_t       trap_vec_i,
    input  fetch_pkg::redirect_t   redirect_i,
    output logic                   ar_valid_o,
    output fetch_pkg::addr_t       ar_addr_o,
    input  logic                   ar_ready_i,
    input  logic                   r_valid_i,
    input  fetch_pkg::inst_t       r_data_i,
    output logic                   r_ready_o,
    output logic                   push_valid_o,
    output fetch_pkg::fetch_item_t push_item_o,
    input  logic                   push_ready_i
);
    import fetch_pkg::*;

    fetch_state_e state_q;
    addr_t        pc_q;
    addr_t        pc_d;
    addr_t        req_addr_q;
    addr_t        redir_pc;
    logic         stale_q;
    logic         redirect_any;
    logic         r_fire;

    // trap wins over the predecode redirect
    assign redirect_any = trap_i || redirect_i.valid;
    assign redir_pc     = trap_i ? trap_vec_i : redirect_i.target;

    assign ar_valid_o = (state_q == ADDR);
    assign ar_addr_o  = req_addr_q;

    // only take a response that the queue can absorb right now
    assign r_ready_o = (state_q == DATA) && push_ready_i;
    assign r_fire    = r_valid_i && r_ready_o;

    // responses to an abandoned address are accepted but never pushed
    assign push_valid_o = r_fire && !stale_q;
    assign push_item_o  = '{pc: req_addr_q, inst: r_data_i};

    always_comb begin
        if (redirect_any) begin
            pc_d = redir_pc;
        end else if (push_valid_o) begin
            pc_d = pc_q + 64'd4;
        end else begin
            pc_d = pc_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            pc_q       <= `FETCH_RESET_PC;
            req_addr_q <= `FETCH_RESET_PC;
            stale_q    <= 1'b0;
        end else begin
            pc_q <= pc_d;
            case (state_q)
                IDLE: begin
                    state_q    <= ADDR;
                    req_addr_q <= pc_d;
                end
                ADDR: begin
                    // address is committed, so mark the read instead of dropping it
                    if (redirect_any) begin
                        stale_q <= 1'b1;
                    end
                    if (ar_ready_i) begin
                        state_q <= DATA;
                    end
                end
                DATA: begin
                    if (r_fire) begin
                        state_q    <= ADDR;
                        req_addr_q <= pc_d;
                        stale_q    <= 1'b0;
                    end else if (redirect_any) begin
                        stale_q <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // redirect targets and trap vectors must keep the bus word aligned
    a_ar_aligned: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ar_valid_o |-> (ar_addr_o[1:0] == 2'b00)
    );

    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o)
    );

endmodule

`default_nettype wire

// ==== design/inst_queue.sv ====
`default_nettype none

`include "fetch_macros.svh"

module inst_queue #(
    parameter int DEPTH = `FETCH_QUEUE_DEPTH
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   flush_i,
    input  logic                   push_valid_i,
    input  fetch_pkg::fetch_item_t push_item_i,
    output logic                   push_ready_o,
    output logic                   pop_valid_o,
    output fetch_pkg::fetch_item_t pop_item_o,
    input  logic                   pop_ready_i
);
    import fetch_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    fetch_item_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push_en;
    logic             pop_en;

    assign push_ready_o = (count_q != CNT_W'(DEPTH));
    // a pushed item shows up one cycle later
    assign pop_valid_o  = (count_q != '0);
    assign pop_item_o   = mem[rd_ptr_q];

    assign push_en = push_valid_i && push_ready_o;
    assign pop_en  = pop_valid_o && pop_ready_i;

    always_ff @(posedge clk) begin
        if (push_en) begin
            mem[wr_ptr_q] <= push_item_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // drop everything including a write in this cycle
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_en, pop_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // the fetch unit must hold off while the queue is full
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        push_valid_i |-> push_ready_o
    );

    // count stays in range and matches the pointer distance
    a_ptr_count: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (count_q <= CNT_W'(DEPTH)) && (PTR_W'(wr_ptr_q - rd_ptr_q) == PTR_W'(count_q))
    );

endmodule

`default_nettype wire

// ==== design/predecode.sv ====
`default_nettype none

`include "fetch_macros.svh"

module predecode (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   trap_i,
    input  logic                   pop_valid_i,
    input  fetch_pkg::fetch_item_t pop_item_i,
    output logic                   pop_ready_o,
    output logic                   out_valid_o,
    output fetch_pkg::fetch_item_t out_item_o,
    input  logic                   out_ready_i,
    output fetch_pkg::redirect_t   redirect_o,
    output logic                   flush_o
);
    import fetch_pkg::*;

    logic        valid_q;
    fetch_item_t item_q;
    logic        out_fire;
    logic        load_en;
    logic        is_jal;
    addr_t       j_imm;

    assign out_valid_o = valid_q;
    assign out_item_o  = item_q;
    assign out_fire    = valid_q && out_ready_i;

    assign is_jal = (item_q.inst[6:0] == `OPC_JAL);

    // j-type immediate, bit 0 always zero
    assign j_imm = {{44{item_q.inst[31]}}, item_q.inst[19:12], item_q.inst[20],
                    item_q.inst[30:21], 1'b0};

    // jump resolves as the jal leaves the stage
    assign redirect_o.valid  = out_fire && is_jal;
    assign redirect_o.target = item_q.pc + j_imm;
    assign flush_o           = redirect_o.valid || trap_i;

    // no new item on a flush edge, the queue is being emptied
    assign pop_ready_o = (!valid_q || out_ready_i) && !flush_o;
    assign load_en     = pop_valid_i && pop_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (trap_i) begin
            valid_q <= 1'b0;
        end else if (load_en) begin
            valid_q <= 1'b1;
        end else if (out_fire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            item_q <= pop_item_i;
        end
    end

    // held item stays put under back-pressure unless a trap kills it
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        out_valid_o && !out_ready_i && !trap_i |=> out_valid_o && $stable(out_item_o)
    );

endmodule

`default_nettype wire

// ==== design/fetch_top.sv ====
`default_nettype none

module fetch_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   trap_i,
    input  fetch_pkg::addr_t       trap_vec_i,
    output logic                   ar_valid_o,
    output fetch_pkg::addr_t       ar_addr_o,
    input  logic                   ar_ready_i,
    input  logic                   r_valid_i,
    input  fetch_pkg::inst_t       r_data_i,
    output logic                   r_ready_o,
    output logic                   out_valid_o,
    output fetch_pkg::fetch_item_t out_item_o,
    input  logic                   out_ready_i
);
    import fetch_pkg::*;

    logic        push_valid;
    fetch_item_t push_item;
    logic        push_ready;
    logic        pop_valid;
    fetch_item_t pop_item;
    logic        pop_ready;
    redirect_t   redirect;
    logic        flush;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .trap_i       (trap_i),
        .trap_vec_i   (trap_vec_i),
        .redirect_i   (redirect),
        .ar_valid_o   (ar_valid_o),
        .ar_addr_o    (ar_addr_o),
        .ar_ready_i   (ar_ready_i),
        .r_valid_i    (r_valid_i),
        .r_data_i     (r_data_i),
        .r_ready_o    (r_ready_o),
        .push_valid_o (push_valid),
        .push_item_o  (push_item),
        .push_ready_i (push_ready)
    );

    // flush covers both jal redirects and traps
    inst_queue u_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .push_valid_i (push_valid),
        .push_item_i  (push_item),
        .push_ready_o (push_ready),
        .pop_valid_o  (pop_valid),
        .pop_item_o   (pop_item),
        .pop_ready_i  (pop_ready)
    );

    predecode u_predecode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .trap_i      (trap_i),
        .pop_valid_i (pop_valid),
        .pop_item_i  (pop_item),
        .pop_ready_o (pop_ready),
        .out_valid_o (out_valid_o),
        .out_item_o  (out_item_o),
        .out_ready_i (out_ready_i),
        .redirect_o  (redirect),
        .flush_o     (flush)
    );

endmodule

`default_nettype wire

// ==== dv/tb_clkgen.sv ====
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // first rising edge at half a period
    always begin
        #(PERIOD / 2);
        clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// ==== dv/tb_fetch.sv ====
`default_nettype none

`include "fetch_macros.svh"

module tb_fetch;
    import fetch_pkg::*;

    localparam int    CLK_PERIOD      = 8;
    localparam int    CYCLES_PER_ITEM = 40;
    localparam int    N_PROG          = 12;
    localparam int    N_PHASES        = 4;
    localparam inst_t NOP             = 32'h0000_0013;

    // program image, any other address reads as nop
    addr_t prog_addr [N_PROG] = '{
        64'h0000_0000_8000_0000, 64'h0000_0000_8000_0004, 64'h0000_0000_8000_0008,
        64'h0000_0000_8000_000c, 64'h0000_0000_8000_0010, 64'h0000_0000_8000_0014,
        64'h0000_0000_8000_0018, 64'h0000_0000_8000_001c, 64'h0000_0000_8000_0020,
        64'h0000_0000_8000_0024, 64'h0000_0000_8000_0100, 64'h0000_0000_8000_0104
    };
    // jal +16 at 0x0c skips three words, jal -20 at 0x24 loops back to 0x10
    inst_t prog_inst [N_PROG] = '{
        32'h0010_0093, 32'h0020_0113, 32'h0030_0193,
        32'h0100_006f, 32'h0040_0213, 32'h0050_0293,
        32'h0060_0313, 32'h0070_0393, 32'h0080_0413,
        32'hfedf_f06f, 32'h0090_0493, 32'h00a0_0513
    };

    // phase table, trap cycle 0 means no trap
    string       ph_name     [N_PHASES] = '{"in_order", "random_stall", "trap_ready", "trap_stall"};
    bit          ph_stall    [N_PHASES] = '{1'b0, 1'b1, 1'b0, 1'b1};
    int unsigned ph_trap_cyc [N_PHASES] = '{0, 0, 5, 7};
    addr_t       ph_vec      [N_PHASES] = '{64'h0, 64'h0, 64'h0000_0000_8000_0100,
                                            64'h0000_0000_8000_0010};
    int unsigned ph_items    [N_PHASES] = '{12, 40, 10, 30};

    logic        clk;
    logic        rst_n_i;
    logic        trap_i;
    addr_t       trap_vec_i;
    logic        ar_valid_o;
    addr_t       ar_addr_o;
    logic        ar_ready_i;
    logic        r_valid_i;
    inst_t       r_data_i;
    logic        r_ready_o;
    logic        out_valid_o;
    fetch_item_t out_item_o;
    logic        out_ready_i;

    // next address the bus should carry, and whether the open read is abandoned
    addr_t       fetch_pc;
    logic        fetch_stale;
    // next pc of the architectural stream
    addr_t       ref_pc;
    logic        ar_checked;
    int unsigned ar_delay;
    logic        rd_pending;
    addr_t       rd_addr;
    int unsigned rd_delay;
    int unsigned items_seen;
    int          error_count;

    tb_clkgen #(
        .PERIOD (CLK_PERIOD)
    ) u_clkgen (
        .clk_o (clk)
    );

    fetch_top u_dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .trap_i      (trap_i),
        .trap_vec_i  (trap_vec_i),
        .ar_valid_o  (ar_valid_o),
        .ar_addr_o   (ar_addr_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_data_i    (r_data_i),
        .r_ready_o   (r_ready_o),
        .out_valid_o (out_valid_o),
        .out_item_o  (out_item_o),
        .out_ready_i (out_ready_i)
    );

    function automatic inst_t mem_read(input addr_t addr);
        inst_t data;
        data = NOP;
        for (int i = 0; i < N_PROG; i++) begin
            if (prog_addr[i] == addr) begin
                data = prog_inst[i];
            end
        end
        return data;
    endfunction

    // j-type immediate as laid out in the isa manual
    function automatic addr_t jal_offset(input inst_t inst);
        logic [20:0] imm;
        imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        return {{43{imm[20]}}, imm};
    endfunction

    task automatic stop_on_error();
        error_count++;
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_item(input string name, input fetch_item_t got, input fetch_item_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got pc=%h inst=%h, expected pc=%h inst=%h",
                     $time, name, got.pc, got.inst, exp.pc, exp.inst);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // one clock of stimulus, memory model and scoreboard
    task automatic run_cycle(input int p, input int unsigned cyc);
        logic        trap_now;
        logic        ar_fire;
        logic        r_fire;
        logic        out_fire;
        logic        redir;
        addr_t       redir_target;
        fetch_item_t exp_item;

        @(negedge clk);
        trap_now    = (ph_trap_cyc[p] != 0) && (cyc == ph_trap_cyc[p]);
        trap_i      = trap_now;
        trap_vec_i  = ph_vec[p];
        out_ready_i = ph_stall[p] ? (($urandom % 2) == 0) : 1'b1;

        // response after 0 to 3 idle cycles, held until taken
        if (!rd_pending) begin
            r_valid_i = 1'b0;
        end else if (!r_valid_i) begin
            if (rd_delay == 0) begin
                r_valid_i = 1'b1;
                r_data_i  = mem_read(rd_addr);
            end else begin
                rd_delay--;
            end
        end

        ar_ready_i = 1'b0;
        if (ar_valid_o) begin
            if (!ar_checked) begin
                check_addr("ar_addr_o[1:0]", addr_t'(ar_addr_o[1:0]), '0);
                check_addr("ar_addr_o", ar_addr_o, fetch_pc);
                ar_checked = 1'b1;
                ar_delay   = $urandom % 4;
            end
            if (ar_delay == 0) begin
                ar_ready_i = 1'b1;
            end else begin
                ar_delay--;
            end
        end

        // everything below is stable until the coming rising edge
        ar_fire      = ar_valid_o && ar_ready_i;
        r_fire       = r_valid_i && r_ready_o;
        out_fire     = out_valid_o && out_ready_i;
        redir        = 1'b0;
        redir_target = '0;

        if (out_fire) begin
            exp_item = '{pc: ref_pc, inst: mem_read(ref_pc)};
            check_item("out_item_o", out_item_o, exp_item);
            items_seen++;
            if (exp_item.inst[6:0] == `OPC_JAL) begin
                ref_pc       = exp_item.pc + jal_offset(exp_item.inst);
                redir        = 1'b1;
                redir_target = ref_pc;
            end else begin
                ref_pc = exp_item.pc + 64'd4;
            end
        end
        // trap overrides a jal leaving in the same cycle
        if (trap_now) begin
            ref_pc       = ph_vec[p];
            redir        = 1'b1;
            redir_target = ph_vec[p];
        end

        if (redir) begin
            fetch_pc = redir_target;
        end else if (r_fire && !fetch_stale) begin
            fetch_pc = fetch_pc + 64'd4;
        end
        if (r_fire) begin
            fetch_stale = 1'b0;
            rd_pending  = 1'b0;
        end else if (redir) begin
            fetch_stale = 1'b1;
        end
        if (ar_fire) begin
            rd_pending = 1'b1;
            rd_addr    = ar_addr_o;
            rd_delay   = $urandom % 4;
            ar_checked = 1'b0;
        end
    endtask

    initial begin : watchdog
        int unsigned total;
        total = 0;
        for (int i = 0; i < N_PHASES; i++) begin
            total += ph_items[i];
        end
        #(total * CYCLES_PER_ITEM * CLK_PERIOD);
        $display("Timeout: the output stream did not finish within %0d cycles",
                 total * CYCLES_PER_ITEM);
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        int unsigned cyc;
        void'($urandom(32'h3925c263));
        rst_n_i     = 1'b0;
        trap_i      = 1'b0;
        trap_vec_i  = '0;
        ar_ready_i  = 1'b0;
        r_valid_i   = 1'b0;
        r_data_i    = '0;
        out_ready_i = 1'b0;
        fetch_pc    = `FETCH_RESET_PC;
        fetch_stale = 1'b0;
        ref_pc      = `FETCH_RESET_PC;
        ar_checked  = 1'b0;
        ar_delay    = 0;
        rd_pending  = 1'b0;
        rd_addr     = '0;
        rd_delay    = 0;
        items_seen  = 0;
        error_count = 0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_flag("ar_valid_o", ar_valid_o, 1'b0);
        check_flag("r_ready_o", r_ready_o, 1'b0);
        check_flag("out_valid_o", out_valid_o, 1'b0);
        rst_n_i = 1'b1;

        for (int p = 0; p < N_PHASES; p++) begin
            $display("phase %s: %0d items", ph_name[p], ph_items[p]);
            items_seen = 0;
            cyc        = 0;
            while (items_seen < ph_items[p] || cyc <= ph_trap_cyc[p]) begin
                run_cycle(p, cyc);
                cyc++;
            end
        end

        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_unit.sv
design/inst_queue.sv
design/predecode.sv
design/fetch_top.sv
dv/tb_clkgen.sv
dv/tb_fetch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, then decide from the simulation log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f files.f --top-module tb_fetch \
    -o tb_fetch_sim > build.log 2>&1 \
    && ./obj_dir/tb_fetch_sim > sim.log 2>&1

grep -qx "Done: no errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL (see build.log and sim.log)"; exit 1; }
